// ==== verilog/async_fifo_pkg.sv ====
`default_nettype none

package async_fifo_pkg;

   // data word width
   localparam int DATA_W = 8;

   // address and pointer width
   localparam int ADDR_W = 4;

   // number of ram words, one slot always stays free
   localparam int DEPTH = 1 << ADDR_W;

   // one stored word
   typedef logic [DATA_W-1:0] fifo_data_t;

   // binary ram address
   typedef logic [ADDR_W-1:0] fifo_addr_t;

   // gray coded pointer, the only value that crosses clock domains
   typedef logic [ADDR_W-1:0] fifo_ptr_t;

   // words held, seen from one side
   typedef logic [ADDR_W-1:0] fifo_level_t;

   // gray to binary, msb first
   function automatic fifo_addr_t gray_to_bin(input fifo_ptr_t gray);
      fifo_addr_t bin;
      bin[ADDR_W-1] = gray[ADDR_W-1];
      for (int i = ADDR_W - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

endpackage : async_fifo_pkg

`default_nettype wire

// ==== verilog/fifo_mem_if.sv ====
`default_nettype none

interface fifo_mem_if
   import async_fifo_pkg::*;
   ;

   // write port, wclk domain
   logic       w_en;
   fifo_addr_t w_addr;
   fifo_data_t w_data;

   // read port, rclk domain
   logic       r_en;
   fifo_addr_t r_addr;
   fifo_data_t r_data;

   // write controller side
   modport wr_side (
      output w_en,
      output w_addr,
      output w_data
   );

   // read controller side
   modport rd_side (
      output r_en,
      output r_addr,
      input  r_data
   );

   // memory side
   modport ram (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface : fifo_mem_if

`default_nettype wire

// ==== verilog/gray_counter.sv ====
`default_nettype none

module gray_counter
   import async_fifo_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      en,
   output fifo_ptr_t ptr
);

   // binary count runs one ahead of the gray output
   fifo_addr_t bin_cnt;
   fifo_ptr_t  gray_q;

   // gray code of the count about to be published
   fifo_ptr_t  gray_next;

   assign gray_next = bin_cnt ^ (bin_cnt >> 1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_cnt <= fifo_addr_t'(1);
         gray_q  <= '0;
      end else if (en) begin
         // gray output equals the number of enabled edges so far
         gray_q  <= gray_next;
         bin_cnt <= bin_cnt + 1'b1;
      end
   end

   assign ptr = gray_q;

endmodule : gray_counter

`default_nettype wire

// ==== verilog/fifo_wr_ctrl.sv ====
`default_nettype none

module fifo_wr_ctrl
   import async_fifo_pkg::*;
(
   input  logic        wclk,
   input  logic        rst,
   input  logic        write_en,
   input  fifo_data_t  data_in,
   input  fifo_ptr_t   rd_ptr,
   output fifo_ptr_t   wr_ptr,
   output logic        full,
   output fifo_level_t level_w,
   fifo_mem_if.wr_side mem
);

   // accepted write
   logic       wr_en_int;

   // read pointer after the two stage synchronizer
   fifo_ptr_t  rd_ptr_s1;
   fifo_ptr_t  rd_ptr_s2;

   // binary views of both pointers
   fifo_addr_t wr_bin;
   fifo_addr_t rd_bin_sync;

   // writes while full are dropped
   assign wr_en_int = write_en & ~full;

   gray_counter u_wr_cnt (
      .clk (wclk),
      .rst (rst),
      .en  (wr_en_int),
      .ptr (wr_ptr)
   );

   // bring the read pointer into wclk
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rd_ptr_s1 <= '0;
         rd_ptr_s2 <= '0;
      end else begin
         rd_ptr_s1 <= rd_ptr;
         rd_ptr_s2 <= rd_ptr_s1;
      end
   end

   assign wr_bin      = gray_to_bin(wr_ptr);
   assign rd_bin_sync = gray_to_bin(rd_ptr_s2);

   // modulo difference, stale read pointer only overstates the level
   assign level_w = wr_bin - rd_bin_sync;

   // one slot stays free so full and empty differ
   assign full = (level_w == fifo_level_t'(DEPTH - 1));

   // ram write port
   assign mem.w_en   = wr_en_int;
   assign mem.w_addr = wr_bin;
   assign mem.w_data = data_in;

endmodule : fifo_wr_ctrl

`default_nettype wire

// ==== verilog/fifo_rd_ctrl.sv ====
`default_nettype none

module fifo_rd_ctrl
   import async_fifo_pkg::*;
(
   input  logic        rclk,
   input  logic        rst,
   input  logic        read_en,
   input  fifo_ptr_t   wr_ptr,
   output fifo_ptr_t   rd_ptr,
   output logic        empty,
   output fifo_level_t level_r,
   output fifo_data_t  rdata,
   fifo_mem_if.rd_side mem
);

   // accepted read
   logic       rd_en_int;

   // write pointer after the two stage synchronizer
   fifo_ptr_t  wr_ptr_s1;
   fifo_ptr_t  wr_ptr_s2;

   // binary views of both pointers
   fifo_addr_t rd_bin;
   fifo_addr_t wr_bin_sync;

   // reads while empty are ignored
   assign rd_en_int = read_en & ~empty;

   gray_counter u_rd_cnt (
      .clk (rclk),
      .rst (rst),
      .en  (rd_en_int),
      .ptr (rd_ptr)
   );

   // bring the write pointer into rclk
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wr_ptr_s1 <= '0;
         wr_ptr_s2 <= '0;
      end else begin
         wr_ptr_s1 <= wr_ptr;
         wr_ptr_s2 <= wr_ptr_s1;
      end
   end

   assign rd_bin      = gray_to_bin(rd_ptr);
   assign wr_bin_sync = gray_to_bin(wr_ptr_s2);

   // stale write pointer only understates the level
   assign level_r = wr_bin_sync - rd_bin;

   assign empty = (level_r == '0);

   // ram read port
   assign mem.r_en   = rd_en_int;
   assign mem.r_addr = rd_bin;

   // ram output register gives the one cycle latency
   // and holds the last word between reads
   assign rdata = mem.r_data;

endmodule : fifo_rd_ctrl

`default_nettype wire

// ==== verilog/dual_clock_ram.sv ====
`default_nettype none

module dual_clock_ram
   import async_fifo_pkg::*;
(
   input  logic    wclk,
   input  logic    rclk,
   input  logic    rst,
   fifo_mem_if.ram mem
);

   // word storage
   fifo_data_t store [DEPTH];

   // registered read data
   fifo_data_t rd_q;

   // write port on wclk
   always_ff @(posedge wclk) begin
      if (mem.w_en) begin
         store[mem.w_addr] <= mem.w_data;
      end
   end

   // read port on rclk, output holds when idle
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         rd_q <= '0;
      end else if (mem.r_en) begin
         rd_q <= store[mem.r_addr];
      end
   end

   assign mem.r_data = rd_q;

endmodule : dual_clock_ram

`default_nettype wire

// ==== verilog/async_fifo_top.sv ====
`default_nettype none

module async_fifo_top
   import async_fifo_pkg::*;
(
   input  logic        wclk,
   input  logic        rclk,
   input  logic        rst,
   input  logic        write_en,
   input  logic        read_en,
   input  fifo_data_t  data_in,
   output fifo_data_t  rdata,
   output logic        full,
   output logic        empty,
   output fifo_level_t level_w,
   output fifo_level_t level_r
);

   // gray pointers crossing between domains
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;

   // ram access bundle
   fifo_mem_if mem_bus ();

   // wclk domain
   fifo_wr_ctrl u_wr_ctrl (
      .wclk     (wclk),
      .rst      (rst),
      .write_en (write_en),
      .data_in  (data_in),
      .rd_ptr   (rd_ptr),
      .wr_ptr   (wr_ptr),
      .full     (full),
      .level_w  (level_w),
      .mem      (mem_bus.wr_side)
   );

   // rclk domain
   fifo_rd_ctrl u_rd_ctrl (
      .rclk    (rclk),
      .rst     (rst),
      .read_en (read_en),
      .wr_ptr  (wr_ptr),
      .rd_ptr  (rd_ptr),
      .empty   (empty),
      .level_r (level_r),
      .rdata   (rdata),
      .mem     (mem_bus.rd_side)
   );

   // storage shared by both domains
   dual_clock_ram u_ram (
      .wclk (wclk),
      .rclk (rclk),
      .rst  (rst),
      .mem  (mem_bus.ram)
   );

endmodule : async_fifo_top

`default_nettype wire

// ==== verif/async_fifo_properties.sv ====
`default_nettype none

module async_fifo_properties
   import async_fifo_pkg::*;
(
   input logic        wclk,
   input logic        rclk,
   input logic        rst,
   input logic        full,
   input logic        empty,
   input fifo_level_t level_w,
   input fifo_ptr_t   wr_ptr,
   input fifo_ptr_t   rd_ptr
);

   // flags never set together
   a_flags_exclusive: assert property (@(posedge wclk) disable iff (rst)
      !(full && empty))
      else $error("full and empty are high at the same time");

   // one slot always stays free, a full fifo never wraps to zero
   a_level_bound: assert property (@(posedge wclk) disable iff (rst)
      level_w == fifo_level_t'(DEPTH - 1) |=> level_w != '0)
      else $error("write side level wrapped past the usable capacity");

   // no read accepted while empty
   a_rd_hold: assert property (@(posedge rclk) disable iff (rst)
      empty |=> $stable(rd_ptr))
      else $error("read pointer moved while empty");

   // no write accepted while full
   a_wr_hold: assert property (@(posedge wclk) disable iff (rst)
      full |=> $stable(wr_ptr))
      else $error("write pointer moved while full");

endmodule : async_fifo_properties

bind async_fifo_top async_fifo_properties u_props (
   .wclk    (wclk),
   .rclk    (rclk),
   .rst     (rst),
   .full    (full),
   .empty   (empty),
   .level_w (level_w),
   .wr_ptr  (wr_ptr),
   .rd_ptr  (rd_ptr)
);

`default_nettype wire

// ==== verif/async_fifo_tb.sv ====
`default_nettype none

module async_fifo_tb
   import async_fifo_pkg::*;
   ;

   typedef logic [8*16-1:0] name_t;

   logic        wclk = 1'b0;
   logic        rclk = 1'b0;
   logic        rst;
   logic        write_en;
   logic        read_en;
   fifo_data_t  data_in;
   fifo_data_t  rdata;
   logic        full;
   logic        empty;
   fifo_level_t level_w;
   fifo_level_t level_r;

   // reference model of the stored words
   fifo_data_t  model_q[$];
   fifo_data_t  last_rdata = '0;
   int          errors = 0;
   int          checks = 0;

   // one entry per line of the tests file
   name_t       t_name[$];
   name_t       t_op[$];
   int          t_count[$];
   int          t_value[$];
   int          t_expect[$];

   async_fifo_top dut0 (
      .wclk     (wclk),
      .rclk     (rclk),
      .rst      (rst),
      .write_en (write_en),
      .read_en  (read_en),
      .data_in  (data_in),
      .rdata    (rdata),
      .full     (full),
      .empty    (empty),
      .level_w  (level_w),
      .level_r  (level_r)
   );

   // unrelated periods so the clocks drift
   always #10 wclk = ~wclk;
   always #17 rclk = ~rclk;

   task automatic check_value(input name_t name, input int expected, input int actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("mismatch %0s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic load_tests();
      int    fd;
      int    n;
      string line;
      name_t name;
      name_t op;
      int    count;
      int    value;
      int    expected;
      fd = $fopen("verif/async_fifo_tests.txt", "r");
      if (fd == 0) begin
         $display("error: cannot open the tests file verif/async_fifo_tests.txt");
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // skip comment and blank lines
         if (n > 0 && line[0] != "#") begin
            n = $sscanf(line, "%s %s %d %h %d", name, op, count, value, expected);
            if (n == 5) begin
               t_name.push_back(name);
               t_op.push_back(op);
               t_count.push_back(count);
               t_value.push_back(value);
               t_expect.push_back(expected);
            end
         end
      end
      $fclose(fd);
      if (t_name.size() == 0) begin
         $display("error: the tests file holds no usable test lines");
         errors++;
      end
   endtask

   task automatic stop_on_timeout(input longint limit);
      #(limit);
      $display("error: the run did not finish within %0d time units", limit);
      $display("SOME TESTS FAILED");
      $finish;
   endtask

   // one extra cycle at the end lets the last write complete
   task automatic write_words(input int count, input int start, input bit rand_mode,
                              output int accepted);
      int unsigned rnd;
      accepted = 0;
      for (int i = 0; i <= count; i++) begin
         @(posedge wclk);
         rnd = $urandom;
         write_en <= (i < count) && (!rand_mode || rnd[0]);
         data_in  <= rand_mode ? rnd[15:8] : fifo_data_t'(start + i);
         // full is stable until the next wclk edge
         @(negedge wclk);
         if (write_en && !full) begin
            model_q.push_back(data_in);
            accepted++;
         end
      end
   endtask

   task automatic read_words(input name_t name, input int count, input bit rand_mode,
                             output int accepted, output int first_word);
      int unsigned rnd;
      logic        pending;
      fifo_data_t  pend_val;
      accepted   = 0;
      first_word = 0;
      pending    = 1'b0;
      pend_val   = '0;
      for (int i = 0; i <= count; i++) begin
         @(posedge rclk);
         rnd = $urandom;
         read_en <= (i < count) && (!rand_mode || rnd[0]);
         @(negedge rclk);
         // rdata moves only after an accepted read
         if (pending) begin
            last_rdata = pend_val;
         end
         check_value(name, int'(last_rdata), int'(rdata));
         pending = read_en && !empty;
         if (pending) begin
            if (model_q.size() == 0) begin
               $display("error: %0s read accepted while the model holds no data", name);
               errors++;
               pending = 1'b0;
            end else begin
               pend_val = model_q.pop_front();
               if (accepted == 0) begin
                  first_word = int'(pend_val);
               end
               accepted++;
            end
         end
      end
   endtask

   task automatic run_test(input name_t name, input name_t op, input int count,
                           input int value, input int expected);
      int wr_acc;
      int rd_acc;
      int first_word;
      case (op)
         name_t'("write"), name_t'("fill"): begin
            write_words(count, value, 1'b0, wr_acc);
            check_value(name, expected, wr_acc);
            if (op == name_t'("fill")) begin
               check_value(name, 1, int'(full));
            end
         end
         name_t'("read"): begin
            read_words(name, count, 1'b0, rd_acc, first_word);
            check_value(name, expected, rd_acc);
            if (rd_acc > 0) begin
               check_value(name, value, first_word);
            end
         end
         name_t'("drain"): begin
            read_words(name, count, 1'b0, rd_acc, first_word);
            repeat (6) @(posedge rclk);
            @(negedge rclk);
            check_value(name, 1, int'(empty));
            check_value(name, expected, int'(level_r));
            check_value(name, expected, model_q.size());
         end
         name_t'("level"): begin
            // both sides idle, pointers settle
            repeat (count) @(posedge rclk);
            @(negedge wclk);
            check_value(name, expected, int'(level_w));
            check_value(name, int'(expected == DEPTH - 1), int'(full));
            @(negedge rclk);
            check_value(name, expected, int'(level_r));
            check_value(name, int'(expected == 0), int'(empty));
            check_value(name, expected, model_q.size());
            check_value(name, int'(last_rdata), int'(rdata));
         end
         name_t'("random"): begin
            fork
               write_words(count, value, 1'b1, wr_acc);
               read_words(name, count, 1'b1, rd_acc, first_word);
            join
         end
         default: begin
            $display("error: unknown operation %0s in test %0s", op, name);
            errors++;
         end
      endcase
   endtask

   initial begin
      int          total;
      longint      limit;
      rst      <= 1'b1;
      write_en <= 1'b0;
      read_en  <= 1'b0;
      data_in  <= '0;
      void'($urandom(32'hae42));
      total    = 0;
      load_tests();
      foreach (t_count[i]) begin
         total += t_count[i];
      end
      limit = longint'(total) * 200 + 10000;
      fork
         stop_on_timeout(limit);
      join_none
      repeat (10) @(posedge wclk);
      rst <= 1'b0;
      foreach (t_name[i]) begin
         run_test(t_name[i], t_op[i], t_count[i], t_value[i], t_expect[i]);
      end
      $display("tests: %0d, checks: %0d, errors: %0d", t_name.size(), checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule : async_fifo_tb

`default_nettype wire

// ==== list.f ====
verilog/async_fifo_pkg.sv
verilog/fifo_mem_if.sv
verilog/gray_counter.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/dual_clock_ram.sv
verilog/async_fifo_top.sv
verif/async_fifo_properties.sv
verif/async_fifo_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the dual-clock FIFO testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module async_fifo_tb \
   -f list.f \
   -o async_fifo_sim

./obj_dir/async_fifo_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// ==== verif/async_fifo_tests.txt ====
# columns: name operation count value expected
# value is the first data word in hex, expected is a word count or a level in decimal
reset_state   level   8   0   0
burst_write   write   10  10  10
burst_settle  level   8   0   10
burst_read    read    10  10  10
order_settle  level   8   0   0
fill_write    fill    15  40  15
fill_extra    write   5   80  0
fill_settle   level   8   0   15
fill_drain    read    15  40  15
empty_drain   drain   4   0   0
empty_read    read    3   0   0
empty_settle  level   8   0   0
part_write    write   6   a0  6
part_settle   level   8   0   6
part_read     read    2   a0  2
part_level    level   8   0   4
rand_traffic  random  200 0   0
rand_drain    drain   24  0   0
final_level   level   8   0   0
